// ==== filelist.f ====
src/fetch_pkg.sv
src/bp_pkg.sv
src/early_imm_decoder.sv
src/branch_predictor.sv
src/pc_ctrl.sv
src/fetch_bundle_former.sv
src/multi_fetch.sv
verif/tb_clock_gen.sv
verif/multi_fetch_tb.sv

// ==== Bender.yml ====
package:
  name: multi_fetch

sources:
  # Packages first, then the RTL bottom up
  - src/fetch_pkg.sv
  - src/bp_pkg.sv
  - src/early_imm_decoder.sv
  - src/branch_predictor.sv
  - src/pc_ctrl.sv
  - src/fetch_bundle_former.sv
  - src/multi_fetch.sv

  # Simulation only
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/multi_fetch_tb.sv

// ==== verif/multi_fetch_tb.sv ====
`timescale 1ns/100ps

module multi_fetch_tb;

   localparam int unsigned      FW         = 5;
   localparam int unsigned      ENTRIES    = 32;
   localparam fetch_pkg::addr_t RESET_PC   = 32'h0;
   localparam int unsigned      MAX_CYCLES = 2000; // Directed tests need about 50 cycles

   logic                   clk;
   logic                   rst_n;
   logic                   bubble;
   logic                   fetch_ready;
   bp_pkg::resolve_t       resolve     [bp_pkg::NUM_RESOLVE];
   fetch_pkg::addr_t       inst_addr   [FW];
   fetch_pkg::inst_t       instruction [FW];
   logic [FW-1:0]          fetch_valid;
   fetch_pkg::fetch_slot_t slots       [FW];

   fetch_pkg::inst_t mem [1024];           // Word-indexed, 4 KiB
   logic [31:0]      lcg_state = 32'd74061;
   fetch_pkg::addr_t exp_pc;               // Start of the next expected bundle
   int unsigned      cycles = 0;

   tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(16)) u_clk (.clk_o(clk), .rst_n_o(rst_n));

   multi_fetch #(.FETCH_WIDTH(FW), .ENTRIES(ENTRIES), .RESET_PC(RESET_PC)) dut0 (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .inst_addr_o   (inst_addr),
      .instruction_i (instruction),
      .bubble_i      (bubble),
      .fetch_ready_i (fetch_ready),
      .resolve_i     (resolve),
      .fetch_valid_o (fetch_valid),
      .slots_o       (slots)
   );

   // Combinational memory, one read port per slot
   always_comb begin
      for (int s = 0; s < FW; s++) begin
         instruction[s] = mem[inst_addr[s][11:2]];
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("ERRORS FOUND");
         $fatal(1, "Run stopped by the cycle limit");
      end
   end

   // ==============================
   // Stimulus helpers
   // ==============================
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Random word with a non-control opcode
   function automatic fetch_pkg::inst_t filler_inst();
      logic [31:0] r;
      logic [6:0]  opc;
      r = lcg_next();
      case (r[31:16] % 6)
         0:       opc = 7'b0000011; // Load
         1:       opc = 7'b0010011; // Op-imm
         2:       opc = 7'b0010111; // AUIPC
         3:       opc = 7'b0100011; // Store
         4:       opc = 7'b0110111; // LUI
         default: opc = 7'b0110011; // R-type, no immediate
      endcase
      return {r[31:7], opc};
   endfunction

   function automatic fetch_pkg::inst_t enc_jal(input int off);
      logic [31:0] o;
      o = off;
      return {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111}; // jal x1
   endfunction

   function automatic fetch_pkg::inst_t enc_branch(input int off);
      logic [31:0] o;
      o = off;
      return {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], 7'b1100011}; // beq x1, x2
   endfunction

   // Expected immediate, built from the RV32I format tables
   function automatic fetch_pkg::imm_t ref_imm(input fetch_pkg::inst_t inst);
      logic [31:0] r;
      r = '0;
      case (inst[6:0])
         7'b0000011, 7'b0010011, 7'b1100111: r = $signed(inst) >>> 20;
         7'b0100011: begin
            r      = $signed(inst) >>> 20;
            r[4:0] = inst[11:7]; // Low bits sit in the rd field
         end
         7'b1100011: begin
            r       = $signed(inst) >>> 19;
            r[11:0] = {inst[7], inst[30:25], inst[11:8], 1'b0};
         end
         7'b0110111, 7'b0010111: r = {inst[31:12], 12'h000};
         7'b1101111: begin
            r       = $signed(inst) >>> 11;
            r[19:0] = {inst[19:12], inst[20], inst[30:21], 1'b0};
         end
         default: r = '0;
      endcase
      return r;
   endfunction

   function automatic bp_pkg::resolve_t make_resolve(input logic misp, upd, jalr, taken,
                                                     input fetch_pkg::addr_t pc, cpc);
      bp_pkg::resolve_t r;
      r.mispredict   = misp;
      r.update_valid = upd;
      r.is_jalr      = jalr;
      r.taken        = taken;
      r.pc           = pc;
      r.correct_pc   = cpc;
      return r;
   endfunction

   // 2 ns after the edge, resolve slots go back to idle
   task automatic next_cycle();
      @(posedge clk);
      #2;
      for (int r = 0; r < bp_pkg::NUM_RESOLVE; r++) begin
         resolve[r] = '0;
      end
   endtask

   task automatic settle();
      #5; // Outputs are stable well before the next edge
   endtask

   // ==============================
   // Checks
   // ==============================
   task automatic check_equal(input logic [31:0] actual, expected, input string msg);
      if (actual !== expected) begin
         $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
         $display("ERRORS FOUND");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic check_bundle(input fetch_pkg::addr_t pc, input logic [FW-1:0] valid_exp,
                               input logic [FW-1:0] taken_exp);
      fetch_pkg::addr_t a;
      check_equal(fetch_valid, valid_exp, "fetch_valid_o");
      for (int s = 0; s < FW; s++) begin
         a = pc + 4 * s;
         check_equal(inst_addr[s], a, $sformatf("inst_addr_o slot %0d", s));
         check_equal(slots[s].pc, a, $sformatf("pc slot %0d", s));
         check_equal(slots[s].inst, mem[a[11:2]], $sformatf("inst slot %0d", s));
         check_equal(slots[s].imm, ref_imm(mem[a[11:2]]), $sformatf("imm slot %0d", s));
         check_equal(slots[s].pred_taken, taken_exp[s], $sformatf("pred_taken slot %0d", s));
      end
   endtask

   // Mispredict on the oldest resolve slot moves fetch to addr
   task automatic redirect_to(input fetch_pkg::addr_t addr);
      next_cycle();
      resolve[0] = make_resolve(1'b1, 1'b0, 1'b0, 1'b0, '0, addr);
      settle();
      check_equal(fetch_valid, '0, "fetch_valid_o during redirect");
      exp_pc = addr;
   endtask

   // ==============================
   // Directed tests
   // ==============================
   task automatic reset_behavior();
      do begin
         next_cycle();
         settle();
         check_equal(fetch_valid, '0, "fetch_valid_o in reset");
      end while (!rst_n);
      while (fetch_valid == '0) begin // Stage starts one edge after release
         next_cycle();
         settle();
      end
      check_bundle(RESET_PC, '1, '0);
      exp_pc = RESET_PC + 4 * FW;
   endtask

   task automatic straight_line_fetch();
      repeat (4) begin
         next_cycle();
         settle();
         check_bundle(exp_pc, '1, '0);
         exp_pc = exp_pc + 4 * FW;
      end
   endtask

   task automatic jal_cut();
      mem[32'h208 / 4] = enc_jal(-256); // Slot 2, backward jump
      redirect_to(32'h200);
      next_cycle();
      settle();
      check_bundle(32'h200, 5'b00111, 5'b00100);
      next_cycle();
      settle();
      check_bundle(32'h108, '1, '0);
      exp_pc = 32'h108 + 4 * FW;
   endtask

   task automatic predictor_training();
      fetch_pkg::addr_t br_pc;
      br_pc = 32'h304;
      mem[br_pc / 4] = enc_branch(96);
      redirect_to(32'h300);
      next_cycle();
      fetch_ready = 1'b0; // Hold bundle, each update shows next cycle
      resolve[0]  = make_resolve(1'b0, 1'b1, 1'b1, 1'b1, br_pc, '0);
      settle();
      check_bundle(32'h300, '0, '0);
      next_cycle();
      resolve[0] = make_resolve(1'b0, 1'b1, 1'b0, 1'b1, br_pc, '0);
      settle();
      check_bundle(32'h300, '0, '0); // JALR update left counter weak
      next_cycle();
      fetch_ready = 1'b1;
      settle();
      check_bundle(32'h300, 5'b00011, 5'b00010);
      next_cycle();
      resolve[0] = make_resolve(1'b0, 1'b1, 1'b0, 1'b0, br_pc, '0);
      resolve[1] = make_resolve(1'b0, 1'b1, 1'b0, 1'b0, br_pc, '0);
      settle();
      check_bundle(32'h364, '1, '0); // Branch target
      next_cycle();
      // Back to the branch, carrying one taken step on the oldest slot
      resolve[0] = make_resolve(1'b1, 1'b1, 1'b0, 1'b1, br_pc, 32'h300);
      settle();
      check_equal(fetch_valid, '0, "fetch_valid_o during redirect");
      next_cycle();
      settle();
      check_bundle(32'h300, '1, '0); // Both not-taken steps landed, one taken step stays low
      exp_pc = 32'h300 + 4 * FW;
   endtask

   task automatic mispredict_priority();
      mem[32'h408 / 4] = enc_branch(32); // Fresh counter, weakly not taken
      next_cycle();
      resolve[1] = make_resolve(1'b1, 1'b0, 1'b0, 1'b0, '0, 32'h400);
      resolve[2] = make_resolve(1'b1, 1'b1, 1'b0, 1'b1, 32'h408, 32'h500);
      settle();
      check_equal(fetch_valid, '0, "fetch_valid_o with two mispredicts");
      next_cycle();
      settle();
      check_bundle(32'h400, '1, '0); // Slot 2 update was wrong path
      exp_pc = 32'h400 + 4 * FW;
   endtask

   task automatic back_pressure();
      next_cycle();
      fetch_ready = 1'b0;
      settle();
      check_bundle(exp_pc, '0, '0);
      next_cycle();
      fetch_ready = 1'b1;
      bubble      = 1'b1;
      settle();
      check_bundle(exp_pc, '0, '0);
      next_cycle();
      bubble = 1'b0;
      settle();
      check_bundle(exp_pc, '1, '0); // Same PC resumes
      exp_pc = exp_pc + 4 * FW;
      next_cycle();
      settle();
      check_bundle(exp_pc, '1, '0);
   endtask

   initial begin
      bubble      = 1'b0;
      fetch_ready = 1'b1;
      exp_pc      = RESET_PC;
      for (int r = 0; r < bp_pkg::NUM_RESOLVE; r++) begin
         resolve[r] = '0;
      end
      for (int i = 0; i < 1024; i++) begin
         mem[i] = filler_inst();
      end
      reset_behavior();
      straight_line_fetch();
      jal_cut();
      predictor_training();
      mispredict_priority();
      back_pressure();
      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
      parameter int unsigned PERIOD       = 20, // ns
      parameter int unsigned RESET_CYCLES = 16
   )(
      output logic clk_o,
      output logic rst_n_o
   );

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   // Release lands 2 ns after an edge, like every other input
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #2 rst_n_o = 1'b1;
   end

endmodule

// ==== src/multi_fetch.sv ====
`timescale 1ns/100ps

module multi_fetch #(
      parameter int unsigned      FETCH_WIDTH = 5,  // Slots per bundle
      parameter int unsigned      ENTRIES     = 32, // Predictor entries, power of two
      parameter fetch_pkg::addr_t RESET_PC    = '0
   )(
      input  logic                   clk_i,
      input  logic                   rst_n_i,

      // Combinational instruction memory
      output fetch_pkg::addr_t       inst_addr_o   [FETCH_WIDTH],
      input  fetch_pkg::inst_t       instruction_i [FETCH_WIDTH],

      input  logic                   bubble_i,
      input  logic                   fetch_ready_i,

      // Resolution feedback, index 0 oldest
      input  bp_pkg::resolve_t       resolve_i     [bp_pkg::NUM_RESOLVE],

      output logic [FETCH_WIDTH-1:0] fetch_valid_o,
      output fetch_pkg::fetch_slot_t slots_o       [FETCH_WIDTH]
   );

   fetch_pkg::addr_t          slot_pc   [FETCH_WIDTH];
   fetch_pkg::predecode_t     predecode [FETCH_WIDTH];
   logic [FETCH_WIDTH-1:0]    pred_taken;
   fetch_pkg::pred_redirect_t pred_redirect;
   logic                      fetch_fire;

   assign inst_addr_o = slot_pc;

   // ==============================
   // Decode, one per slot
   // ==============================
   generate
      for (genvar s = 0; s < FETCH_WIDTH; s++) begin : g_dec
         early_imm_decoder u_dec (
            .instruction_i (instruction_i[s]),
            .predecode_o   (predecode[s])
         );
      end
   endgenerate

   // ==============================
   // Execute
   // ==============================
   branch_predictor #(.FETCH_WIDTH(FETCH_WIDTH), .ENTRIES(ENTRIES)) u_bp (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .slot_pc_i    (slot_pc),
      .predecode_i  (predecode),
      .resolve_i    (resolve_i),
      .pred_taken_o (pred_taken)
   );

   pc_ctrl #(.FETCH_WIDTH(FETCH_WIDTH), .RESET_PC(RESET_PC)) u_pc (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .bubble_i        (bubble_i),
      .fetch_ready_i   (fetch_ready_i),
      .resolve_i       (resolve_i),
      .pred_redirect_i (pred_redirect),  // Target of first taken slot
      .slot_pc_o       (slot_pc),
      .fetch_fire_o    (fetch_fire)
   );

   // Result
   fetch_bundle_former #(.FETCH_WIDTH(FETCH_WIDTH)) u_former (
      .fetch_fire_i    (fetch_fire),
      .slot_pc_i       (slot_pc),
      .instruction_i   (instruction_i),
      .predecode_i     (predecode),
      .pred_taken_i    (pred_taken),
      .fetch_valid_o   (fetch_valid_o),
      .slots_o         (slots_o),
      .pred_redirect_o (pred_redirect)
   );

endmodule

// ==== src/fetch_bundle_former.sv ====
`timescale 1ns/100ps

module fetch_bundle_former #(
      parameter int unsigned FETCH_WIDTH = 5
   )(
      input  logic                      fetch_fire_i,
      input  fetch_pkg::addr_t          slot_pc_i     [FETCH_WIDTH],
      input  fetch_pkg::inst_t          instruction_i [FETCH_WIDTH],
      input  fetch_pkg::predecode_t     predecode_i   [FETCH_WIDTH],
      input  logic [FETCH_WIDTH-1:0]    pred_taken_i,

      output logic [FETCH_WIDTH-1:0]    fetch_valid_o,
      output fetch_pkg::fetch_slot_t    slots_o       [FETCH_WIDTH],
      output fetch_pkg::pred_redirect_t pred_redirect_o
   );

   localparam int unsigned SLOT_W = (FETCH_WIDTH > 1) ? $clog2(FETCH_WIDTH) : 1;

   logic              hit;       // Some slot predicted taken
   logic [SLOT_W-1:0] first_idx; // Lowest predicted-taken slot

   // ==============================
   // Cut after first taken slot
   // ==============================
   always_comb begin
      hit       = 1'b0;
      first_idx = '0;
      for (int s = 0; s < FETCH_WIDTH; s++) begin
         fetch_valid_o[s] = fetch_fire_i & ~hit; // Taken slot itself stays valid
         if (!hit && pred_taken_i[s]) begin
            hit       = 1'b1;
            first_idx = SLOT_W'(s);
         end
      end
   end

   // PC-relative target of the taken slot
   assign pred_redirect_o.valid  = hit;
   assign pred_redirect_o.target = slot_pc_i[first_idx] + predecode_i[first_idx].imm;

   // Slot records
   generate
      for (genvar s = 0; s < FETCH_WIDTH; s++) begin : g_slot
         assign slots_o[s].pc         = slot_pc_i[s];
         assign slots_o[s].inst       = instruction_i[s];
         assign slots_o[s].imm        = predecode_i[s].imm;
         assign slots_o[s].pred_taken = pred_taken_i[s];
      end
   endgenerate

endmodule

// ==== src/pc_ctrl.sv ====
`timescale 1ns/100ps

module pc_ctrl #(
      parameter int unsigned      FETCH_WIDTH = 5,
      parameter fetch_pkg::addr_t RESET_PC    = '0
   )(
      input  logic                     clk_i,
      input  logic                     rst_n_i,
      input  logic                     bubble_i,
      input  logic                     fetch_ready_i,
      input  bp_pkg::resolve_t         resolve_i [bp_pkg::NUM_RESOLVE],
      input  fetch_pkg::pred_redirect_t pred_redirect_i,

      output fetch_pkg::addr_t         slot_pc_o [FETCH_WIDTH],
      output logic                     fetch_fire_o
   );

   localparam fetch_pkg::addr_t BUNDLE_BYTES = fetch_pkg::addr_t'(4 * FETCH_WIDTH);

   fetch_pkg::addr_t pc_q;
   fetch_pkg::addr_t pc_d;
   logic             run_q;    // Low until first edge after reset release
   logic             misp_any;
   fetch_pkg::addr_t misp_pc;

   // ==============================
   // Oldest mispredict redirect
   // ==============================
   always_comb begin
      misp_any = 1'b0;
      misp_pc  = '0;
      for (int r = bp_pkg::NUM_RESOLVE - 1; r >= 0; r--) begin
         if (resolve_i[r].mispredict) begin // Lower index written last, so oldest wins
            misp_any = 1'b1;
            misp_pc  = resolve_i[r].correct_pc;
         end
      end
   end

   assign fetch_fire_o = run_q & fetch_ready_i & ~bubble_i & ~misp_any;

   // Next PC, mispredict outranks back-pressure
   always_comb begin
      if (misp_any)                   pc_d = misp_pc;
      else if (!fetch_fire_o)         pc_d = pc_q;                    // Hold the bundle
      else if (pred_redirect_i.valid) pc_d = pred_redirect_i.target;
      else                            pc_d = pc_q + BUNDLE_BYTES;     // Sequential
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_q  <= RESET_PC;
         run_q <= 1'b0;
      end else begin
         pc_q  <= pc_d;
         run_q <= 1'b1;
      end
   end

   // Consecutive word addresses
   generate
      for (genvar s = 0; s < FETCH_WIDTH; s++) begin : g_slot_pc
         assign slot_pc_o[s] = pc_q + fetch_pkg::addr_t'(4 * s);
      end
   endgenerate

endmodule

// ==== src/branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor #(
      parameter int unsigned FETCH_WIDTH = 5,
      parameter int unsigned ENTRIES     = 32 // Power of two
   )(
      input  logic                  clk_i,
      input  logic                  rst_n_i,

      input  fetch_pkg::addr_t      slot_pc_i   [FETCH_WIDTH],
      input  fetch_pkg::predecode_t predecode_i [FETCH_WIDTH],
      input  bp_pkg::resolve_t      resolve_i   [bp_pkg::NUM_RESOLVE],

      output logic [FETCH_WIDTH-1:0] pred_taken_o
   );

   localparam int unsigned IDX_W = $clog2(ENTRIES); // PC bits above the byte offset

   bp_pkg::ctr_t     table_q [ENTRIES]; // Bimodal counter table
   bp_pkg::ctr_t     table_d [ENTRIES];
   logic             older_misp;        // An older resolve slot already mispredicted
   logic [IDX_W-1:0] upd_idx;

   // ==============================
   // Lookup, one port per slot
   // ==============================
   generate
      for (genvar s = 0; s < FETCH_WIDTH; s++) begin : g_lookup
         logic [IDX_W-1:0] rd_idx;

         assign rd_idx = slot_pc_i[s][IDX_W+1:2];
         // JAL always taken, branch follows counter MSB
         assign pred_taken_o[s] = predecode_i[s].is_jal |
                                  (predecode_i[s].is_branch & table_q[rd_idx][1]);
      end
   endgenerate

   // ==============================
   // Ordered update, oldest first
   // ==============================
   always_comb begin
      table_d    = table_q;
      older_misp = 1'b0;
      upd_idx    = '0;
      for (int r = 0; r < bp_pkg::NUM_RESOLVE; r++) begin
         upd_idx = resolve_i[r].pc[IDX_W+1:2];
         // Younger than a mispredict means wrong path, drop it
         if (resolve_i[r].update_valid && !resolve_i[r].is_jalr && !older_misp) begin
            table_d[upd_idx] = bp_pkg::ctr_step(table_d[upd_idx], resolve_i[r].taken);
         end
         older_misp = older_misp | resolve_i[r].mispredict;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int e = 0; e < ENTRIES; e++) begin
            table_q[e] <= bp_pkg::CTR_RESET; // All weakly not taken
         end
      end else begin
         table_q <= table_d; // Visible to lookups from next cycle
      end
   end

endmodule

// ==== src/early_imm_decoder.sv ====
`timescale 1ns/100ps

module early_imm_decoder (
      input  fetch_pkg::inst_t      instruction_i,
      output fetch_pkg::predecode_t predecode_o
   );

   fetch_pkg::opcode_t opcode;
   fetch_pkg::imm_t    imm_i_type;
   fetch_pkg::imm_t    imm_s_type;
   fetch_pkg::imm_t    imm_b_type;
   fetch_pkg::imm_t    imm_u_type;
   fetch_pkg::imm_t    imm_j_type;

   assign opcode = instruction_i[6:0];

   // ==============================
   // Immediates of every format
   // ==============================
   assign imm_i_type = {{20{instruction_i[31]}}, instruction_i[31:20]};
   assign imm_s_type = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
   assign imm_b_type = {{19{instruction_i[31]}}, instruction_i[31], instruction_i[7],
                        instruction_i[30:25], instruction_i[11:8], 1'b0}; // Half-word aligned
   assign imm_u_type = {instruction_i[31:12], 12'b0};                     // Upper-placed
   assign imm_j_type = {{11{instruction_i[31]}}, instruction_i[31], instruction_i[19:12],
                        instruction_i[20], instruction_i[30:21], 1'b0};

   // Control-flow flags
   assign predecode_o.is_branch = (opcode == fetch_pkg::OPC_BRANCH);
   assign predecode_o.is_jal    = (opcode == fetch_pkg::OPC_JAL);
   assign predecode_o.is_jalr   = (opcode == fetch_pkg::OPC_JALR);

   // Format select by opcode
   always_comb begin
      case (opcode)
         fetch_pkg::OPC_LOAD,
         fetch_pkg::OPC_OP_IMM,
         fetch_pkg::OPC_JALR:   predecode_o.imm = imm_i_type;
         fetch_pkg::OPC_STORE:  predecode_o.imm = imm_s_type;
         fetch_pkg::OPC_BRANCH: predecode_o.imm = imm_b_type;
         fetch_pkg::OPC_LUI,
         fetch_pkg::OPC_AUIPC:  predecode_o.imm = imm_u_type;
         fetch_pkg::OPC_JAL:    predecode_o.imm = imm_j_type;
         default:               predecode_o.imm = '0; // R-type, system, fence
      endcase
   end

endmodule

// ==== src/bp_pkg.sv ====
package bp_pkg;

   // ==============================
   // Resolution interface
   // ==============================
   localparam int unsigned NUM_RESOLVE = 3; // In-order resolve slots, 0 is oldest

   typedef logic [1:0] ctr_t; // Two-bit saturating counter, MSB means taken

   localparam ctr_t CTR_RESET = 2'b01; // Weakly not taken
   localparam ctr_t CTR_MAX   = 2'b11;
   localparam ctr_t CTR_MIN   = 2'b00;

   // One resolved control-flow instruction, 68 bits
   typedef struct packed {
      logic             mispredict;   // Fetch went the wrong way
      logic             update_valid; // Outcome is known, train predictor
      logic             is_jalr;      // Indirect jump, no counter to train
      logic             taken;        // Resolved direction
      fetch_pkg::addr_t pc;           // PC the prediction was made for
      fetch_pkg::addr_t correct_pc;   // Where fetch must resume
   } resolve_t;

   // One step toward the resolved direction, saturating at both ends
   function automatic ctr_t ctr_step(ctr_t ctr, logic taken);
      ctr_t nxt;
      nxt = ctr;
      if (taken && (ctr != CTR_MAX)) nxt = ctr + 2'd1;
      else if (!taken && (ctr != CTR_MIN)) nxt = ctr - 2'd1;
      return nxt;
   endfunction

endpackage

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

   // ==============================
   // Datapath widths
   // ==============================
   typedef logic [31:0] addr_t;   // Byte address of an instruction
   typedef logic [31:0] inst_t;   // Raw instruction word
   typedef logic [31:0] imm_t;    // Sign-extended immediate
   typedef logic [6:0]  opcode_t; // RV32I major opcode

   // RV32I major opcodes seen by the pre-decoder
   localparam opcode_t OPC_LOAD   = 7'b0000011;
   localparam opcode_t OPC_OP_IMM = 7'b0010011;
   localparam opcode_t OPC_AUIPC  = 7'b0010111;
   localparam opcode_t OPC_STORE  = 7'b0100011;
   localparam opcode_t OPC_LUI    = 7'b0110111;
   localparam opcode_t OPC_BRANCH = 7'b1100011;
   localparam opcode_t OPC_JALR   = 7'b1100111;
   localparam opcode_t OPC_JAL    = 7'b1101111;

   // Pre-decode result for one slot, 35 bits
   typedef struct packed {
      logic is_branch;  // Conditional branch, B-type
      logic is_jal;     // Direct jump, always taken
      logic is_jalr;    // Indirect jump, fetched as fall-through
      imm_t imm;        // Immediate of the decoded format
   } predecode_t;

   // One delivered slot, 97 bits
   typedef struct packed {
      addr_t pc;
      inst_t inst;
      imm_t  imm;
      logic  pred_taken; // Slot ends the bundle with a taken prediction
   } fetch_slot_t;

   // Predicted redirect out of the bundle former
   typedef struct packed {
      logic  valid;
      addr_t target;
   } pred_redirect_t;

endpackage
